/* common/alut_pkg.sv */
package alut_pkg;

   // ------------------------------------------------------------------
   // widths with a meaning
   // ------------------------------------------------------------------
   typedef logic [47:0] mac_t;    // ethernet address
   typedef logic [1:0]  port_t;   // switch port number
   typedef logic [31:0] stamp_t;  // time value
   typedef logic [4:0]  fwd_t;    // bits 3:0 ports, bit 4 own cpu

   // one table entry, 83 bits
   typedef struct packed {
      logic   valid;
      mac_t   mac;
      port_t  port;
      stamp_t stamp;
   } alut_entry_t;

   // frame under test, from the register bank
   typedef struct packed {
      mac_t  d_addr;
      mac_t  s_addr;
      port_t s_port;
   } frame_req_t;

   // one invalidated entry, valid for a cycle
   typedef struct packed {
      logic  valid;
      mac_t  mac;
      port_t port;
   } inval_evt_t;

   typedef enum logic [1:0] {
      cmd_none  = 2'd0,
      cmd_check = 2'd1,
      cmd_age   = 2'd2,
      cmd_clear = 2'd3
   } alut_cmd_e;

   typedef enum logic [2:0] {
      st_idle, st_scan_chk, st_write_chk, st_scan_age, st_clear
   } ctrl_state_e;

   localparam mac_t bcast_mac = '1;  // broadcast destination

endpackage

/* common/alut_regs_pkg.sv */
package alut_regs_pkg;

   typedef logic [6:0]  apb_addr_t;
   typedef logic [31:0] apb_data_t;

   // ------------------------------------------------------------------
   // register map, one word apart
   // ------------------------------------------------------------------
   localparam apb_addr_t al_frm_d_addr_l   = 7'h00;
   localparam apb_addr_t al_frm_d_addr_u   = 7'h04;  // 16 bits used
   localparam apb_addr_t al_frm_s_addr_l   = 7'h08;
   localparam apb_addr_t al_frm_s_addr_u   = 7'h0C;  // 16 bits used
   localparam apb_addr_t al_s_port         = 7'h10;
   localparam apb_addr_t al_d_port         = 7'h14;  // read only
   localparam apb_addr_t al_mac_addr_l     = 7'h18;
   localparam apb_addr_t al_mac_addr_u     = 7'h1C;
   localparam apb_addr_t al_cur_time       = 7'h20;  // read only
   localparam apb_addr_t al_bb_age         = 7'h24;
   localparam apb_addr_t al_div_clk        = 7'h28;
   localparam apb_addr_t al_command        = 7'h2C;  // write only, self clearing
   localparam apb_addr_t al_status         = 7'h30;  // read clears reused
   localparam apb_addr_t al_lst_inv_addr_l = 7'h34;
   localparam apb_addr_t al_lst_inv_addr_u = 7'h38;
   localparam apb_addr_t al_lst_inv_port   = 7'h3C;

   // reset values
   localparam apb_data_t bb_age_reset = 32'hffff_ffff;  // nothing ages out

endpackage

/* src/alut_timer.sv */
`timescale 1ns/1ns

module alut_timer
(
   input  logic              pclk26,
   input  logic              n_p_reset26,
   input  logic [7:0]        div_clk,      // ticks every div_clk+1 cycles
   output alut_pkg::stamp_t  curr_time
);
   import alut_pkg::*;

   logic [7:0] pre_q;   // prescaler

   always_ff @(posedge pclk26 or negedge n_p_reset26)
   begin
      if (!n_p_reset26)
      begin
         pre_q     <= '0;
         curr_time <= '0;
      end
      else if (pre_q >= div_clk)                 // also catches a lowered divider
      begin
         pre_q     <= '0;
         curr_time <= curr_time + stamp_t'(1);
      end
      else
         pre_q <= pre_q + 8'd1;
   end

endmodule

/* alut/alut_mem.sv */
`timescale 1ns/1ns

module alut_mem #(
   parameter  int alut_depth = 4,
   localparam int idx_w      = $clog2(alut_depth)
)
(
   input  logic                   pclk26,
   input  logic                   n_p_reset26,
   input  logic [idx_w-1:0]       rd_idx,
   input  logic                   wr_en,
   input  logic [idx_w-1:0]       wr_idx,
   input  alut_pkg::alut_entry_t  wr_entry,
   input  logic                   tbl_clear,
   output alut_pkg::alut_entry_t  rd_entry
);
   import alut_pkg::*;

   alut_entry_t           mem_q [alut_depth];   // payload
   logic [alut_depth-1:0] vld_q;                // valid bits kept apart for clearing

   always_ff @(posedge pclk26 or negedge n_p_reset26)
   begin
      if (!n_p_reset26)
         vld_q <= '0;
      else if (tbl_clear)
         vld_q <= '0;                               // clear all
      else if (wr_en)
         vld_q[wr_idx] <= wr_entry.valid;
   end

   always_ff @(posedge pclk26)
   begin
      if (wr_en)
         mem_q[wr_idx] <= wr_entry;
   end

   // combinational read, same cycle as the index
   always_comb
   begin
      rd_entry       = mem_q[rd_idx];
      rd_entry.valid = vld_q[rd_idx];
   end

endmodule

/* alut/alut_age_checker.sv */
`timescale 1ns/1ns

module alut_age_checker #(
   parameter  int alut_depth = 4,
   localparam int idx_w      = $clog2(alut_depth)
)
(
   input  logic                   pclk26,
   input  logic                   n_p_reset26,
   input  logic                   scan_age,
   input  logic [idx_w-1:0]       scan_idx,
   input  alut_pkg::alut_entry_t  rd_entry,
   input  alut_pkg::stamp_t       curr_time,
   input  alut_pkg::stamp_t       best_bfr_age,
   output logic                   age_wr_en,
   output logic [idx_w-1:0]       age_wr_idx,
   output alut_pkg::alut_entry_t  age_wr_entry,
   output alut_pkg::inval_evt_t   evt_cmd
);
   import alut_pkg::*;

   stamp_t age;       // wraps with the timer
   logic   expired;

   assign age     = curr_time - rd_entry.stamp;
   assign expired = scan_age & rd_entry.valid & (age > best_bfr_age);

   // write back the same slot with valid dropped
   assign age_wr_en    = expired;
   assign age_wr_idx   = scan_idx;
   always_comb
   begin
      age_wr_entry       = rd_entry;
      age_wr_entry.valid = 1'b0;
   end

   // one event per invalidated entry, the last one wins in the bank
   always_ff @(posedge pclk26 or negedge n_p_reset26)
   begin
      if (!n_p_reset26)
         evt_cmd <= '0;
      else
         evt_cmd <= '{valid: expired, mac: rd_entry.mac, port: rd_entry.port};
   end

endmodule

/* alut/alut_addr_checker.sv */
`timescale 1ns/1ns

module alut_addr_checker #(
   parameter  int alut_depth = 4,
   localparam int idx_w      = $clog2(alut_depth)
)
(
   input  logic                   pclk26,
   input  logic                   n_p_reset26,
   input  logic                   scan_chk,
   input  logic                   scan_last,
   input  logic [idx_w-1:0]       scan_idx,
   input  alut_pkg::alut_entry_t  rd_entry,
   input  alut_pkg::frame_req_t   frm,
   input  alut_pkg::mac_t         mac_addr,
   input  alut_pkg::stamp_t       curr_time,
   output logic                   chk_wr_en,
   output logic [idx_w-1:0]       chk_wr_idx,
   output alut_pkg::alut_entry_t  chk_wr_entry,
   output alut_pkg::fwd_t         d_port,
   output alut_pkg::inval_evt_t   evt_nrm
);
   import alut_pkg::*;

   logic             wr_step_q;                       // cycle after the last index
   logic             src_hit_q, dst_hit_q, free_hit_q;
   logic [idx_w-1:0] src_idx_q, free_idx_q, rr_ptr_q;
   port_t            dst_port_q;
   mac_t             victim_mac_q;                    // entry under rr_ptr
   port_t            victim_port_q;
   logic             first;
   logic             replace;

   assign first   = scan_idx == '0;                   // restart the gather
   assign replace = ~src_hit_q & ~free_hit_q;         // table full, unknown source

   // match flags, cleared at the first index of every scan
   always_ff @(posedge pclk26 or negedge n_p_reset26)
   begin
      if (!n_p_reset26)
      begin
         wr_step_q  <= 1'b0;
         src_hit_q  <= 1'b0;
         dst_hit_q  <= 1'b0;
         free_hit_q <= 1'b0;
      end
      else
      begin
         wr_step_q <= scan_chk & scan_last;
         if (scan_chk)
         begin
            src_hit_q  <= (src_hit_q & ~first) |
                          (rd_entry.valid & (rd_entry.mac == frm.s_addr));
            dst_hit_q  <= (dst_hit_q & ~first) |
                          (rd_entry.valid & (rd_entry.mac == frm.d_addr));
            free_hit_q <= (free_hit_q & ~first) | ~rd_entry.valid;
         end
      end
   end

   // payload of the gather, qualified by the flags above
   always_ff @(posedge pclk26)
   begin
      if (scan_chk)
      begin
         if (rd_entry.valid && rd_entry.mac == frm.s_addr)
            src_idx_q <= scan_idx;
         if (rd_entry.valid && rd_entry.mac == frm.d_addr)
            dst_port_q <= rd_entry.port;
         if (!rd_entry.valid && (first || !free_hit_q))
            free_idx_q <= scan_idx;                   // lowest free slot only
         if (scan_idx == rr_ptr_q)
         begin
            victim_mac_q  <= rd_entry.mac;
            victim_port_q <= rd_entry.port;
         end
      end
   end

   // learning write, matching slot, else free slot, else replace slot
   assign chk_wr_en    = wr_step_q;
   assign chk_wr_idx   = src_hit_q ? src_idx_q : free_hit_q ? free_idx_q : rr_ptr_q;
   assign chk_wr_entry = '{valid: 1'b1, mac: frm.s_addr, port: frm.s_port,
                           stamp: curr_time};

   always_ff @(posedge pclk26 or negedge n_p_reset26)
   begin
      if (!n_p_reset26)
      begin
         rr_ptr_q <= '0;
         evt_nrm  <= '0;
         d_port   <= '0;
      end
      else
      begin
         evt_nrm <= '{valid: wr_step_q & replace, mac: victim_mac_q, port: victim_port_q};
         if (wr_step_q && replace)
            rr_ptr_q <= (rr_ptr_q == idx_w'(alut_depth - 1)) ? '0 : rr_ptr_q + 1'b1;
         if (wr_step_q)
         begin
            if (frm.d_addr == mac_addr)
               d_port <= 5'b1_0000;                   // for the cpu itself
            else if (frm.d_addr != bcast_mac && dst_hit_q)
               d_port <= fwd_t'(1) << dst_port_q;
            else
               d_port <= {1'b0, 4'b1111 & ~(4'b0001 << frm.s_port)};  // flood
         end
      end
   end

endmodule

/* alut/alut_ctrl.sv */
`timescale 1ns/1ns

module alut_ctrl #(
   parameter  int alut_depth = 4,
   localparam int idx_w      = $clog2(alut_depth)
)
(
   input  logic                   pclk26,
   input  logic                   n_p_reset26,
   input  alut_pkg::alut_cmd_e    cmd,
   output logic [idx_w-1:0]       scan_idx,
   output logic                   scan_chk,
   output logic                   scan_age,
   output logic                   scan_last,
   output logic                   tbl_clear,
   output logic                   active,
   output logic                   inval_in_prog,
   input  logic                   chk_wr_en,
   input  logic [idx_w-1:0]       chk_wr_idx,
   input  alut_pkg::alut_entry_t  chk_wr_entry,
   input  logic                   age_wr_en,
   input  logic [idx_w-1:0]       age_wr_idx,
   input  alut_pkg::alut_entry_t  age_wr_entry,
   output logic                   wr_en,
   output logic [idx_w-1:0]       wr_idx,
   output alut_pkg::alut_entry_t  wr_entry
);
   import alut_pkg::*;

   localparam logic [idx_w-1:0] last_idx = idx_w'(alut_depth - 1);

   ctrl_state_e      state_q;
   logic [idx_w-1:0] idx_q;
   logic             at_last;

   assign at_last = idx_q == last_idx;

   // ------------------------------------------------------------------
   // sequencer
   // ------------------------------------------------------------------
   always_ff @(posedge pclk26 or negedge n_p_reset26)
   begin
      if (!n_p_reset26)
      begin
         state_q <= st_idle;
         idx_q   <= '0;
      end
      else
      begin
         case (state_q)
            st_idle :
            begin
               idx_q <= '0;
               case (cmd)                  // busy commands never reach here
                  cmd_check : state_q <= st_scan_chk;
                  cmd_age   : state_q <= st_scan_age;
                  cmd_clear : state_q <= st_clear;
                  default   : state_q <= st_idle;
               endcase
            end
            st_scan_chk :
            begin
               idx_q <= at_last ? '0 : idx_q + 1'b1;
               if (at_last)
                  state_q <= st_write_chk;  // one learning write
            end
            st_scan_age :
            begin
               idx_q <= at_last ? '0 : idx_q + 1'b1;
               if (at_last)
                  state_q <= st_idle;
            end
            default : state_q <= st_idle;   // write_chk and clear last one cycle
         endcase
      end
   end

   assign scan_idx      = idx_q;
   assign scan_chk      = state_q == st_scan_chk;
   assign scan_age      = state_q == st_scan_age;
   assign scan_last     = (scan_chk | scan_age) & at_last;
   assign tbl_clear     = state_q == st_clear;
   assign active        = scan_chk | (state_q == st_write_chk);
   assign inval_in_prog = scan_age;

   // table write port follows whichever checker owns the state
   always_comb
   begin
      wr_en    = 1'b0;
      wr_idx   = chk_wr_idx;
      wr_entry = chk_wr_entry;
      if (state_q == st_write_chk)
         wr_en = chk_wr_en;
      else if (scan_age)
      begin
         wr_en    = age_wr_en;
         wr_idx   = age_wr_idx;
         wr_entry = age_wr_entry;
      end
   end

endmodule

/* alut/alut_reg_bank.sv */
`timescale 1ns/1ns

module alut_reg_bank
(
   input  logic                      pclk26,
   input  logic                      n_p_reset26,
   input  logic                      psel,
   input  logic                      penable,
   input  logic                      pwrite,
   input  alut_regs_pkg::apb_addr_t  paddr,
   input  alut_regs_pkg::apb_data_t  pwdata,
   input  alut_pkg::stamp_t          curr_time,
   input  logic                      active,          // check running
   input  logic                      inval_in_prog,   // sweep running
   input  alut_pkg::fwd_t            d_port,
   input  alut_pkg::inval_evt_t      evt_nrm,         // eviction by learning
   input  alut_pkg::inval_evt_t      evt_cmd,         // invalidation by sweep
   output alut_regs_pkg::apb_data_t  prdata,
   output alut_pkg::frame_req_t      frm,
   output alut_pkg::mac_t            mac_addr,
   output alut_pkg::stamp_t          best_bfr_age,
   output logic [7:0]                div_clk,
   output alut_pkg::alut_cmd_e       cmd
);
   import alut_pkg::*;
   import alut_regs_pkg::*;

   logic  rd_en;          // setup phase of a read
   logic  wr_en;          // access phase of a write
   logic  busy;           // status bit 0
   logic  reused;         // sticky, full table overwrite
   mac_t  lst_inv_addr;
   port_t lst_inv_port;

   assign rd_en = psel & ~penable & ~pwrite;
   assign wr_en = psel & penable & pwrite;
   // a pending command already counts as busy for polling software
   assign busy  = active | (cmd != cmd_none);

   // ------------------------------------------------------------------
   // writable registers
   // ------------------------------------------------------------------
   always_ff @(posedge pclk26 or negedge n_p_reset26)
   begin
      if (!n_p_reset26)
      begin
         frm          <= '0;
         mac_addr     <= '0;
         best_bfr_age <= bb_age_reset;
         div_clk      <= '0;
      end
      else if (wr_en)
      begin
         case (paddr)
            al_frm_d_addr_l : frm.d_addr[31:0]  <= pwdata;
            al_frm_d_addr_u : frm.d_addr[47:32] <= pwdata[15:0];
            al_frm_s_addr_l : frm.s_addr[31:0]  <= pwdata;
            al_frm_s_addr_u : frm.s_addr[47:32] <= pwdata[15:0];
            al_s_port       : frm.s_port        <= pwdata[1:0];
            al_mac_addr_l   : mac_addr[31:0]    <= pwdata;
            al_mac_addr_u   : mac_addr[47:32]   <= pwdata[15:0];
            al_bb_age       : best_bfr_age      <= pwdata;
            al_div_clk      : div_clk           <= pwdata[7:0];
            default         : ;                 // read only or unmapped
         endcase
      end
   end

   // command lives for one cycle only
   always_ff @(posedge pclk26 or negedge n_p_reset26)
   begin
      if (!n_p_reset26)
         cmd <= cmd_none;
      else if (cmd != cmd_none)
         cmd <= cmd_none;
      else if (wr_en && paddr == al_command)
         cmd <= alut_cmd_e'(pwdata[1:0]);
   end

   // ------------------------------------------------------------------
   // status and last invalidated entry
   // ------------------------------------------------------------------
   always_ff @(posedge pclk26 or negedge n_p_reset26)
   begin
      if (!n_p_reset26)
         reused <= 1'b0;
      else if (evt_nrm.valid)
         reused <= 1'b1;                           // set wins over clear
      else if (rd_en && paddr == al_status && !busy)
         reused <= 1'b0;                           // read to clear
   end

   always_ff @(posedge pclk26 or negedge n_p_reset26)
   begin
      if (!n_p_reset26)
      begin
         lst_inv_addr <= '0;
         lst_inv_port <= '0;
      end
      else if (evt_nrm.valid)         // learning eviction first
      begin
         lst_inv_addr <= evt_nrm.mac;
         lst_inv_port <= evt_nrm.port;
      end
      else if (evt_cmd.valid)
      begin
         lst_inv_addr <= evt_cmd.mac;
         lst_inv_port <= evt_cmd.port;
      end
   end

   // registered read mux, zero outside the access phase
   always_ff @(posedge pclk26 or negedge n_p_reset26)
   begin
      if (!n_p_reset26)
         prdata <= '0;
      else if (rd_en)
      begin
         case (paddr)
            al_frm_d_addr_l   : prdata <= frm.d_addr[31:0];
            al_frm_d_addr_u   : prdata <= {16'd0, frm.d_addr[47:32]};
            al_frm_s_addr_l   : prdata <= frm.s_addr[31:0];
            al_frm_s_addr_u   : prdata <= {16'd0, frm.s_addr[47:32]};
            al_s_port         : prdata <= {30'd0, frm.s_port};
            al_d_port         : prdata <= {27'd0, d_port};
            al_mac_addr_l     : prdata <= mac_addr[31:0];
            al_mac_addr_u     : prdata <= {16'd0, mac_addr[47:32]};
            al_cur_time       : prdata <= curr_time;
            al_bb_age         : prdata <= best_bfr_age;
            al_div_clk        : prdata <= {24'd0, div_clk};
            al_status         : prdata <= {29'd0, reused, inval_in_prog, busy};
            al_lst_inv_addr_l : prdata <= lst_inv_addr[31:0];
            al_lst_inv_addr_u : prdata <= {16'd0, lst_inv_addr[47:32]};
            al_lst_inv_port   : prdata <= {30'd0, lst_inv_port};
            default           : prdata <= '0;
         endcase
      end
      else
         prdata <= '0;
   end

endmodule

/* alut/alut_top.sv */
`timescale 1ns/1ns

module alut_top #(
   parameter  int alut_depth = 4,
   localparam int idx_w      = $clog2(alut_depth)
)
(
   input  logic                      pclk26,
   input  logic                      n_p_reset26,
   input  logic                      psel,
   input  logic                      penable,
   input  logic                      pwrite,
   input  alut_regs_pkg::apb_addr_t  paddr,
   input  alut_regs_pkg::apb_data_t  pwdata,
   output alut_regs_pkg::apb_data_t  prdata
);
   import alut_pkg::*;

   // ------------------------------------------------------------------
   // configuration and results
   // ------------------------------------------------------------------
   frame_req_t  frm;
   mac_t        mac_addr;
   stamp_t      best_bfr_age, curr_time;
   logic [7:0]  div_clk;
   alut_cmd_e   cmd;
   fwd_t        d_port;
   inval_evt_t  evt_nrm, evt_cmd;
   logic        active, inval_in_prog;

   // scan and table write
   logic [idx_w-1:0] scan_idx, chk_wr_idx, age_wr_idx, wr_idx;
   logic             scan_chk, scan_age, scan_last, tbl_clear;
   logic             chk_wr_en, age_wr_en, wr_en;
   alut_entry_t      rd_entry, chk_wr_entry, age_wr_entry, wr_entry;

   alut_reg_bank u_reg_bank (.pclk26, .n_p_reset26, .psel, .penable, .pwrite, .paddr,
      .pwdata, .curr_time, .active, .inval_in_prog, .d_port, .evt_nrm, .evt_cmd,
      .prdata, .frm, .mac_addr, .best_bfr_age, .div_clk, .cmd);

   alut_ctrl #(.alut_depth(alut_depth)) u_ctrl (.pclk26, .n_p_reset26, .cmd,
      .scan_idx, .scan_chk, .scan_age, .scan_last, .tbl_clear, .active, .inval_in_prog,
      .chk_wr_en, .chk_wr_idx, .chk_wr_entry, .age_wr_en, .age_wr_idx, .age_wr_entry,
      .wr_en, .wr_idx, .wr_entry);

   alut_addr_checker #(.alut_depth(alut_depth)) u_addr_checker (.pclk26, .n_p_reset26,
      .scan_chk, .scan_last, .scan_idx, .rd_entry, .frm, .mac_addr, .curr_time,
      .chk_wr_en, .chk_wr_idx, .chk_wr_entry, .d_port, .evt_nrm);

   alut_age_checker #(.alut_depth(alut_depth)) u_age_checker (.pclk26, .n_p_reset26,
      .scan_age, .scan_idx, .rd_entry, .curr_time, .best_bfr_age,
      .age_wr_en, .age_wr_idx, .age_wr_entry, .evt_cmd);

   alut_mem #(.alut_depth(alut_depth)) u_mem (.pclk26, .n_p_reset26, .rd_idx(scan_idx),
      .wr_en, .wr_idx, .wr_entry, .tbl_clear, .rd_entry);

   alut_timer u_timer (.pclk26, .n_p_reset26, .div_clk, .curr_time);

endmodule

/* tb/tb_alut.sv */
`timescale 1ns/1ns

module tb_alut;
   import alut_pkg::*;
   import alut_regs_pkg::*;

   localparam int depth      = 4;
   localparam int max_cycles = 20000;  // about ten times the expected run

   logic      pclk26;
   logic      n_p_reset26;
   logic      psel, penable, pwrite;
   apb_addr_t paddr;
   apb_data_t pwdata, prdata;
   int        cycles = 0;

   // reference table
   logic  m_valid [depth];
   mac_t  m_mac [depth];
   port_t m_port [depth];
   int    m_rr;                           // replace pointer
   logic  ev_hit;                         // last learn evicted an entry
   mac_t  ev_mac;
   port_t ev_port;
   mac_t  macs [7];                       // stations 0 to 5 and own mac at 6
   mac_t  own_mac;

   alut_top #(.alut_depth(depth)) alut_top_i (.pclk26, .n_p_reset26, .psel, .penable,
      .pwrite, .paddr, .pwdata, .prdata);

   initial
   begin
      pclk26 = 1'b0;
      forever #20 pclk26 = ~pclk26;       // 40 ns period
   end

   always @(posedge pclk26)
   begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles)
      begin
         $display("timeout: the run did not finish within %0d cycles", max_cycles);
         $display("*** TEST FAILED ***");
         $fatal(1, "run stopped by the cycle limit");
      end
   end

   // ------------------------------------------------------------------
   // apb access
   // ------------------------------------------------------------------
   task automatic apb_write(input apb_addr_t a, input apb_data_t d);
      @(posedge pclk26);
      psel    <= 1'b1;   // setup
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= a;
      pwdata  <= d;
      @(posedge pclk26);
      penable <= 1'b1;   // access
      @(posedge pclk26);
      psel    <= 1'b0;   // write lands on this edge
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic apb_read(input apb_addr_t a, output apb_data_t d);
      @(posedge pclk26);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= a;
      @(posedge pclk26);  // prdata registered here
      penable <= 1'b1;
      @(negedge pclk26);
      d = prdata;         // stable mid access phase
      @(posedge pclk26);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic write_mac(input apb_addr_t a_l, input mac_t m);
      apb_write(a_l, m[31:0]);
      apb_write(apb_addr_t'(a_l + 7'd4), {16'd0, m[47:32]});
   endtask

   // ------------------------------------------------------------------
   // compare tasks
   // ------------------------------------------------------------------
   task automatic check_data(input apb_data_t got, input apb_data_t exp, input string what);
      if (got !== exp)
      begin
         $display("error at %0t ns: %s read %h, expected %h", $time, what, got, exp);
         $display("*** TEST FAILED ***");
         $fatal(1, "data mismatch");
      end
   endtask

   task automatic check_fwd(input fwd_t got, input fwd_t exp);
      if (got !== exp)
      begin
         $display("error at %0t ns: forward vector %b, expected %b", $time, got, exp);
         $display("*** TEST FAILED ***");
         $fatal(1, "forward mismatch");
      end
   endtask

   task automatic check_evt(input mac_t got_mac, input port_t got_port,
                            input mac_t exp_mac, input port_t exp_port);
      if (got_mac !== exp_mac || got_port !== exp_port)
      begin
         $display("error at %0t ns: last invalidated %h/%0d, expected %h/%0d",
                  $time, got_mac, got_port, exp_mac, exp_port);
         $display("*** TEST FAILED ***");
         $fatal(1, "invalidation mismatch");
      end
   endtask

   // ------------------------------------------------------------------
   // reference model
   // ------------------------------------------------------------------
   function automatic fwd_t ref_fwd(input mac_t d, input port_t sp);
      fwd_t v;
      v = '0;
      if (d == own_mac)
         return 5'b1_0000;
      if (d != bcast_mac)
         for (int i = 0; i < depth; i++)
            if (m_valid[i] && m_mac[i] == d)
            begin
               v[m_port[i]] = 1'b1;
               return v;
            end
      for (int p = 0; p < 4; p++)
         v[p] = (p != sp);             // flood except the source port
      return v;
   endfunction

   task automatic model_learn(input mac_t s, input port_t sp);
      int slot;
      slot   = -1;
      ev_hit = 1'b0;
      for (int i = 0; i < depth; i++)
         if (m_valid[i] && m_mac[i] == s)
            slot = i;
      for (int i = 0; i < depth; i++)
         if (slot < 0 && !m_valid[i])
            slot = i;                 // lowest free slot
      if (slot < 0)
      begin
         slot    = m_rr;              // table full so evict
         ev_hit  = 1'b1;
         ev_mac  = m_mac[slot];
         ev_port = m_port[slot];
         m_rr    = (m_rr + 1) % depth;
      end
      m_valid[slot] = 1'b1;
      m_mac[slot]   = s;
      m_port[slot]  = sp;
   endtask

   // ------------------------------------------------------------------
   // commands and lookups
   // ------------------------------------------------------------------
   task automatic run_cmd(input alut_cmd_e c, output logic seen);
      apb_data_t d;
      int        polls;
      polls = 0;
      seen  = 1'b0;
      apb_write(al_command, 32'(c));
      do
      begin
         apb_read(al_status, d);
         seen  = seen | d[2];        // a poll may consume the sticky bit
         polls = polls + 1;
         if (polls > 100)
         begin
            $display("status register stayed busy after command %0d", c);
            $display("*** TEST FAILED ***");
            $fatal(1, "command never finished");
         end
      end
      while (d[1:0] != 2'b00);
   endtask

   task automatic check_last_inv(input mac_t m, input port_t p);
      apb_data_t lo, hi, pt;
      apb_read(al_lst_inv_addr_l, lo);
      apb_read(al_lst_inv_addr_u, hi);
      apb_read(al_lst_inv_port, pt);
      check_evt({hi[15:0], lo}, pt[1:0], m, p);
   endtask

   task automatic lookup(input mac_t d, input mac_t s, input port_t sp);
      fwd_t      exp;
      apb_data_t data;
      logic      seen;
      write_mac(al_frm_d_addr_l, d);
      write_mac(al_frm_s_addr_l, s);
      apb_write(al_s_port, {30'd0, sp});
      exp = ref_fwd(d, sp);          // table before learning
      model_learn(s, sp);
      run_cmd(cmd_check, seen);
      apb_read(al_status, data);
      seen = seen | data[2];
      check_data({31'd0, seen}, {31'd0, ev_hit}, "reused flag");
      apb_read(al_d_port, data);
      check_fwd(fwd_t'(data), exp);
      if (ev_hit)
         check_last_inv(ev_mac, ev_port);
   endtask

   // ------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------
   initial
   begin
      apb_data_t d, t0, t1;
      apb_addr_t wr_regs [9];
      apb_data_t masks [9];
      logic      seen, dup;
      int        last;

      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      n_p_reset26 = 1'b0;
      void'($urandom(32'h55db));
      for (int i = 0; i < 7; i++)
      begin
         do
         begin
            macs[i] = mac_t'({$urandom(), $urandom()});
            dup     = (macs[i] == bcast_mac) || (macs[i] == '0);
            for (int j = 0; j < i; j++)
               dup = dup | (macs[j] == macs[i]);
         end
         while (dup);
      end
      own_mac = macs[6];
      for (int i = 0; i < depth; i++)
         m_valid[i] = 1'b0;
      m_rr = 0;
      repeat (4) @(posedge pclk26);
      n_p_reset26 <= 1'b1;

      // reset values while time already runs
      for (int a = 0; a <= 'h3C; a += 4)
      begin
         if (apb_addr_t'(a) == al_cur_time)
            continue;
         apb_read(apb_addr_t'(a), d);
         check_data(d, apb_addr_t'(a) == al_bb_age ? bb_age_reset : '0, "reset value");
      end

      // readback with masks
      wr_regs = '{al_frm_d_addr_l, al_frm_d_addr_u, al_frm_s_addr_l, al_frm_s_addr_u,
                  al_s_port, al_mac_addr_l, al_mac_addr_u, al_bb_age, al_div_clk};
      masks   = '{32'hffff_ffff, 32'h0000_ffff, 32'hffff_ffff, 32'h0000_ffff,
                  32'h3, 32'hffff_ffff, 32'h0000_ffff, 32'hffff_ffff, 32'hff};
      for (int i = 0; i < 9; i++)
      begin
         t0 = $urandom();
         apb_write(wr_regs[i], t0);
         apb_read(wr_regs[i], d);
         check_data(d, t0 & masks[i], "readback");
      end
      apb_write(7'h40, $urandom());   // unmapped and ignored
      apb_read(7'h40, d);
      check_data(d, '0, "unmapped");
      apb_read(7'h7C, d);
      check_data(d, '0, "unmapped");
      apb_read(al_command, d);
      check_data(d, '0, "command");

      // forwarding
      apb_write(al_bb_age, bb_age_reset);
      apb_write(al_div_clk, 32'd0);
      write_mac(al_mac_addr_l, own_mac);
      lookup(bcast_mac, macs[0], 2'd0);
      lookup(macs[4], macs[1], 2'd1);
      lookup(macs[2], macs[2], 2'd2);   // self and not yet known
      lookup(macs[0], macs[3], 2'd3);
      lookup(own_mac, macs[1], 2'd1);
      lookup(macs[3], macs[0], 2'd2);   // moves to port 2
      lookup(macs[0], macs[1], 2'd1);

      // replacement in a full table
      lookup(macs[1], macs[4], 2'd1);
      apb_read(al_status, d);
      check_data({31'd0, d[2]}, '0, "second status read");

      // ageing with nothing old enough
      run_cmd(cmd_age, seen);
      check_data({31'd0, seen}, '0, "reused after sweep");
      check_last_inv(ev_mac, ev_port);  // no entry aged out
      lookup(macs[4], macs[1], 2'd1);
      apb_write(al_bb_age, 32'd0);
      repeat (3) @(posedge pclk26);
      run_cmd(cmd_age, seen);
      check_data({31'd0, seen}, '0, "reused after sweep");
      last = -1;
      for (int i = 0; i < depth; i++)
         if (m_valid[i])
            last = i;
      for (int i = 0; i < depth; i++)
         m_valid[i] = 1'b0;           // every entry expired
      check_last_inv(m_mac[last], m_port[last]);
      lookup(macs[2], macs[3], 2'd3);
      lookup(macs[1], macs[0], 2'd0);
      apb_write(al_bb_age, bb_age_reset);

      // clear
      for (int i = 0; i < 4; i++)
         lookup(bcast_mac, macs[i], port_t'(i));
      run_cmd(cmd_clear, seen);
      check_data({31'd0, seen}, '0, "reused after clear");
      for (int i = 0; i < depth; i++)
         m_valid[i] = 1'b0;
      lookup(macs[0], macs[4], 2'd0);
      lookup(macs[1], macs[5], 2'd2);

      // timer
      apb_read(al_cur_time, t0);
      for (int i = 0; i < 4; i++)
      begin
         apb_read(al_cur_time, t1);
         if (t1 < t0)
            check_data(t1, t0, "time went backwards");
         t0 = t1;
      end
      apb_write(al_div_clk, 32'd3);   // tick every 4 cycles
      apb_read(al_cur_time, t0);
      repeat (512) @(posedge pclk26);
      apb_read(al_cur_time, t1);
      if (t1 - t0 < 127 || t1 - t0 > 129)
         check_data(t1 - t0, 32'd128, "time step over 512 cycles");

      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

/* filelist.f */
common/alut_pkg.sv
common/alut_regs_pkg.sv
src/alut_timer.sv
alut/alut_mem.sv
alut/alut_age_checker.sv
alut/alut_addr_checker.sv
alut/alut_ctrl.sv
alut/alut_reg_bank.sv
alut/alut_top.sv
tb/tb_alut.sv

/* run.sh */
#!/bin/sh
# build and run the lookup table testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_alut -f filelist.f -o tb_alut_sim

# the simulator may exit non-zero on failure, the log decides
./obj_dir/tb_alut_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
   exit 0
else
   exit 1
fi
